//--- common/kalman_pkg.sv
// Shared EKF constants, the fixed-point multiply rule and the covariance sequencer states
package kalman_pkg;

  localparam int MAT_DIM  = 4;
  localparam int MEAS_DIM = 2;

  // Motor model
  localparam real RS_OHM    = 1.477;
  localparam real LS_HENRY  = 0.0211;
  localparam real LAMBDA_WB = 0.2026;
  localparam real TS_SEC    = 0.00001;

  // Process noise diagonal
  localparam real Q_DIAG_0 = 0.01;
  localparam real Q_DIAG_1 = 0.01;
  localparam real Q_DIAG_2 = 20.0;
  localparam real Q_DIAG_3 = 0.0001;

  // Measurement noise, same on both current channels
  localparam real R_DIAG = 0.92;

  // Covariance after reset
  localparam real P_INIT_0 = 1.0;
  localparam real P_INIT_1 = 10.0;
  localparam real P_INIT_2 = 5.0;
  localparam real P_INIT_3 = 5.0;

  typedef enum logic [2:0] {
    IDLE,
    PRED_FP,
    PRED_FPF,
    GAIN_DIV,
    GAIN_MUL,
    COV_UPD,
    DONE
  } cov_state_e;

  // Signed product, floor-shifted by the fraction count; callers keep the low bits
  function automatic logic signed [63:0] q_mul(input logic signed [63:0] a,
                                               input logic signed [63:0] b,
                                               input int frac);
    logic signed [127:0] prod;
    prod = a * b;
    return 64'(prod >>> frac);
  endfunction

endpackage

//--- hw/covariance/mat_mult_seq.sv
// Sequential fixed-point 4x4 matrix multiplier, one row-major result element per clock
`timescale 1ns/1ps

module mat_mult_seq
  import kalman_pkg::*;
#(
  parameter int WIDTH = 32,
  parameter int FRAC  = 18
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                start_i,
  input  logic [MAT_DIM*MAT_DIM*WIDTH-1:0]    a_i,
  input  logic [MAT_DIM*MAT_DIM*WIDTH-1:0]    b_i,
  output logic                                done_o,
  output logic [MAT_DIM*MAT_DIM*WIDTH-1:0]    c_o
);

  localparam int NE = MAT_DIM * MAT_DIM;
  localparam int IW = $clog2(NE);

  logic             busy;
  logic [IW-1:0]    idx;
  logic [WIDTH-1:0] elem;

  // Dot product of one row of A with one column of B, wrapping sum
  always_comb begin
    logic signed [63:0] prod;
    int row;
    int col;
    row  = int'(idx) / MAT_DIM;
    col  = int'(idx) % MAT_DIM;
    elem = '0;
    for (int k = 0; k < MAT_DIM; k++) begin
      prod = q_mul($signed(a_i[(row*MAT_DIM+k)*WIDTH +: WIDTH]),
                   $signed(b_i[(k*MAT_DIM+col)*WIDTH +: WIDTH]), FRAC);
      elem = elem + prod[WIDTH-1:0];
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      busy   <= 1'b0;
      idx    <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        busy <= 1'b1;
        idx  <= '0;
      end else if (busy) begin
        idx <= idx + 1'b1;
        if (idx == IW'(NE - 1)) begin
          busy   <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  // Result words are overwritten in order and then held
  always_ff @(posedge clk) begin
    if (busy) c_o[idx*WIDTH +: WIDTH] <= elem;
  end

  assert property (@(posedge clk) disable iff (!reset) start_i |-> !busy)
    else $error("mat_mult_seq: start while a multiply is in progress");

endmodule

//--- hw/covariance/recip_div.sv
// Serial restoring divider giving the fixed-point reciprocal of the innovation determinant
`timescale 1ns/1ps

module recip_div #(
  parameter int WIDTH = 32,
  parameter int FRAC  = 18
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start_i,
  input  logic signed [WIDTH-1:0] det_i,
  output logic                    done_o,
  output logic signed [WIDTH-1:0] recip_o
);

  localparam int DW = WIDTH + FRAC;
  localparam int CW = $clog2(DW + 1);
  localparam logic [WIDTH-1:0] MAX_POS = {1'b0, {(WIDTH-1){1'b1}}};

  logic             busy, neg;
  logic [CW-1:0]    cnt;
  logic [WIDTH-1:0] divisor, q_sat;
  logic [WIDTH:0]   rem, rem_shift;
  // Dividend shifts out of the top while quotient bits enter at the bottom
  logic [DW-1:0]    quot;

  assign rem_shift = {rem[WIDTH-1:0], quot[DW-1]};
  assign q_sat     = (|quot[DW-1:WIDTH-1]) ? MAX_POS : quot[WIDTH-1:0];

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      busy   <= 1'b0;
      cnt    <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy && cnt != CW'(DW)) begin
        cnt <= cnt + 1'b1;
      end else if (busy) begin
        busy   <= 1'b0;
        done_o <= 1'b1;
      end
    end
  end

  // A zero divisor sets every quotient bit, which saturates to the largest positive value
  always_ff @(posedge clk) begin
    if (start_i) begin
      quot    <= DW'(1) << (2 * FRAC);
      rem     <= '0;
      divisor <= det_i[WIDTH-1] ? -det_i : det_i;
      neg     <= det_i[WIDTH-1];
    end else if (busy && cnt != CW'(DW)) begin
      if (rem_shift >= {1'b0, divisor}) begin
        rem  <= rem_shift - {1'b0, divisor};
        quot <= {quot[DW-2:0], 1'b1};
      end else begin
        rem  <= rem_shift;
        quot <= {quot[DW-2:0], 1'b0};
      end
    end else if (busy) begin
      recip_o <= neg ? -q_sat : q_sat;
    end
  end

  // Done is registered WIDTH+FRAC+1 edges after start, so it is sampled one edge later
  assert property (@(posedge clk) disable iff (!reset) done_o |-> $past(start_i, WIDTH + FRAC + 2))
    else $error("recip_div: done without a matching start");

endmodule

//--- hw/covariance/covariance_update.sv
// Covariance sequencer: predicted covariance, innovation inverse, Kalman gain and update
`timescale 1ns/1ps

module covariance_update
  import kalman_pkg::*;
#(
  parameter int WIDTH = 32,
  parameter int FRAC  = 18
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    predict_done_i,
  input  logic signed [WIDTH-1:0] jac_02_i,
  input  logic signed [WIDTH-1:0] jac_03_i,
  input  logic signed [WIDTH-1:0] jac_12_i,
  input  logic signed [WIDTH-1:0] jac_13_i,
  input  logic                    step_done_i,
  output logic                    gain_valid_o,
  output logic signed [WIDTH-1:0] k_00_o,
  output logic signed [WIDTH-1:0] k_01_o,
  output logic signed [WIDTH-1:0] k_10_o,
  output logic signed [WIDTH-1:0] k_11_o,
  output logic signed [WIDTH-1:0] k_20_o,
  output logic signed [WIDTH-1:0] k_21_o,
  output logic signed [WIDTH-1:0] k_30_o,
  output logic signed [WIDTH-1:0] k_31_o
);

  localparam int  NE    = MAT_DIM * MAT_DIM;
  localparam real SCALE = 2.0 ** FRAC;
  localparam logic signed [WIDTH-1:0] SF     = WIDTH'(1) << FRAC;
  localparam logic signed [WIDTH-1:0] F_DIAG = SF - $rtoi(RS_OHM * TS_SEC / LS_HENRY * SCALE);
  localparam logic signed [WIDTH-1:0] TS_FX  = $rtoi(TS_SEC * SCALE);
  localparam logic signed [WIDTH-1:0] R_FX   = $rtoi(R_DIAG * SCALE);
  localparam logic [MAT_DIM-1:0][WIDTH-1:0] Q_FX = {
    WIDTH'($rtoi(Q_DIAG_3 * SCALE)), WIDTH'($rtoi(Q_DIAG_2 * SCALE)),
    WIDTH'($rtoi(Q_DIAG_1 * SCALE)), WIDTH'($rtoi(Q_DIAG_0 * SCALE))
  };

  cov_state_e              state;
  logic                    mm_start, mm_done, div_start, div_done;
  logic                    mm_busy, div_busy;
  logic [NE-1:0][WIDTH-1:0] p_q, fp_q, pp_q, k_q, mm_a, mm_b, mm_c;
  logic [NE-1:0][WIDTH-1:0] f_m, ft_m, pct_m, inv_m, ikc_m;
  logic signed [WIDTH-1:0] s00, s11, p01, p10, det, recip;

  // Innovation matrix S = Pp[0:1][0:1] + R and its determinant
  assign p01 = pp_q[1];
  assign p10 = pp_q[MAT_DIM];
  assign s00 = pp_q[0] + R_FX;
  assign s11 = pp_q[MAT_DIM+1] + R_FX;
  assign det = WIDTH'(q_mul(s00, s11, FRAC)) - WIDTH'(q_mul(p10, p01, FRAC));

  always_comb begin
    f_m            = '0;
    f_m[0]         = F_DIAG;
    f_m[2]         = jac_02_i;
    f_m[3]         = jac_03_i;
    f_m[5]         = F_DIAG;
    f_m[6]         = jac_12_i;
    f_m[7]         = jac_13_i;
    f_m[10]        = SF;
    f_m[14]        = TS_FX;
    f_m[15]        = SF;
    // Adjugate of S scaled by the reciprocal of its determinant
    inv_m          = '0;
    inv_m[0]       = WIDTH'(q_mul(s11, recip, FRAC));
    inv_m[1]       = WIDTH'(q_mul(-p01, recip, FRAC));
    inv_m[MAT_DIM] = WIDTH'(q_mul(-p10, recip, FRAC));
    inv_m[5]       = WIDTH'(q_mul(s00, recip, FRAC));
    for (int r = 0; r < MAT_DIM; r++) begin
      for (int c = 0; c < MAT_DIM; c++) begin
        ft_m[c*MAT_DIM+r]  = f_m[r*MAT_DIM+c];
        pct_m[r*MAT_DIM+c] = (c < MEAS_DIM) ? pp_q[r*MAT_DIM+c] : '0;
        ikc_m[r*MAT_DIM+c] = ((r == c) ? SF : '0) - ((c < MEAS_DIM) ? k_q[r*MAT_DIM+c] : '0);
      end
    end
  end

  // Multiplier operands follow the sequencer state
  always_comb begin
    case (state)
      PRED_FP: begin
        mm_a = f_m;
        mm_b = p_q;
      end
      PRED_FPF: begin
        mm_a = fp_q;
        mm_b = ft_m;
      end
      GAIN_MUL: begin
        mm_a = pct_m;
        mm_b = inv_m;
      end
      default: begin
        mm_a = ikc_m;
        mm_b = pp_q;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state        <= IDLE;
      mm_start     <= 1'b0;
      div_start    <= 1'b0;
      gain_valid_o <= 1'b0;
      p_q          <= '0;
      p_q[0]       <= WIDTH'($rtoi(P_INIT_0 * SCALE));
      p_q[5]       <= WIDTH'($rtoi(P_INIT_1 * SCALE));
      p_q[10]      <= WIDTH'($rtoi(P_INIT_2 * SCALE));
      p_q[15]      <= WIDTH'($rtoi(P_INIT_3 * SCALE));
    end else begin
      mm_start     <= 1'b0;
      div_start    <= 1'b0;
      gain_valid_o <= 1'b0;
      case (state)
        IDLE: if (predict_done_i) begin
          mm_start <= 1'b1;
          state    <= PRED_FP;
        end
        PRED_FP: if (mm_done) begin
          mm_start <= 1'b1;
          state    <= PRED_FPF;
        end
        PRED_FPF: if (mm_done) begin
          div_start <= 1'b1;
          state     <= GAIN_DIV;
        end
        GAIN_DIV: if (div_done) begin
          mm_start <= 1'b1;
          state    <= GAIN_MUL;
        end
        GAIN_MUL: if (mm_done) begin
          mm_start <= 1'b1;
          state    <= COV_UPD;
        end
        COV_UPD: if (mm_done) begin
          gain_valid_o <= 1'b1;
          state        <= DONE;
        end
        // Updated covariance stays in the multiplier until the step completes
        DONE: if (step_done_i) begin
          p_q   <= mm_c;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == PRED_FP && mm_done) fp_q <= mm_c;
    if (state == PRED_FPF && mm_done) begin
      for (int i = 0; i < NE; i++) begin
        pp_q[i] <= mm_c[i] + ((i % (MAT_DIM + 1) == 0) ? Q_FX[i/(MAT_DIM+1)] : '0);
      end
    end
    if (state == GAIN_MUL && mm_done) k_q <= mm_c;
  end

  // Set by a start, cleared by the matching done
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      mm_busy  <= 1'b0;
      div_busy <= 1'b0;
    end else begin
      if (mm_start) begin
        mm_busy <= 1'b1;
      end else if (mm_done) begin
        mm_busy <= 1'b0;
      end
      if (div_start) begin
        div_busy <= 1'b1;
      end else if (div_done) begin
        div_busy <= 1'b0;
      end
    end
  end

  assign k_00_o = k_q[0];
  assign k_01_o = k_q[1];
  assign k_10_o = k_q[4];
  assign k_11_o = k_q[5];
  assign k_20_o = k_q[8];
  assign k_21_o = k_q[9];
  assign k_30_o = k_q[12];
  assign k_31_o = k_q[13];

  mat_mult_seq #(.WIDTH(WIDTH), .FRAC(FRAC)) u_mm (
    .clk, .reset, .start_i(mm_start), .a_i(mm_a), .b_i(mm_b), .done_o(mm_done), .c_o(mm_c)
  );

  recip_div #(.WIDTH(WIDTH), .FRAC(FRAC)) u_div (
    .clk, .reset, .start_i(div_start), .det_i(det), .done_o(div_done), .recip_o(recip)
  );

  // No operation starts while the multiplier or the divider is still running
  assert property (@(posedge clk) disable iff (!reset)
    (mm_start || div_start) |-> !(mm_busy || div_busy))
    else $error("covariance_update: start while a submodule is busy");

endmodule

//--- hw/predict/state_predict.sv
// Mean prediction: latches a sample, then registers the predicted state and Jacobian terms
`timescale 1ns/1ps

module state_predict
  import kalman_pkg::*;
#(
  parameter int WIDTH = 32,
  parameter int FRAC  = 18
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sample_valid_i,
  input  logic                    sample_ready_i,
  input  logic signed [WIDTH-1:0] v_alpha_i,
  input  logic signed [WIDTH-1:0] v_beta_i,
  input  logic signed [WIDTH-1:0] i_alpha_meas_i,
  input  logic signed [WIDTH-1:0] i_beta_meas_i,
  input  logic signed [WIDTH-1:0] cos_theta_i,
  input  logic signed [WIDTH-1:0] sin_theta_i,
  input  logic signed [WIDTH-1:0] x_0_i,
  input  logic signed [WIDTH-1:0] x_1_i,
  input  logic signed [WIDTH-1:0] x_2_i,
  input  logic signed [WIDTH-1:0] x_3_i,
  output logic                    predict_done_o,
  output logic signed [WIDTH-1:0] xe_0_o,
  output logic signed [WIDTH-1:0] xe_1_o,
  output logic signed [WIDTH-1:0] xe_2_o,
  output logic signed [WIDTH-1:0] xe_3_o,
  output logic signed [WIDTH-1:0] jac_02_o,
  output logic signed [WIDTH-1:0] jac_03_o,
  output logic signed [WIDTH-1:0] jac_12_o,
  output logic signed [WIDTH-1:0] jac_13_o,
  output logic signed [WIDTH-1:0] meas_alpha_o,
  output logic signed [WIDTH-1:0] meas_beta_o
);

  localparam real SCALE = 2.0 ** FRAC;
  // Discretized motor coefficients
  localparam logic signed [WIDTH-1:0] RS_TS_LS  = $rtoi(RS_OHM * TS_SEC / LS_HENRY * SCALE);
  localparam logic signed [WIDTH-1:0] LAM_TS_LS = $rtoi(LAMBDA_WB * TS_SEC / LS_HENRY * SCALE);
  localparam logic signed [WIDTH-1:0] TS_LS     = $rtoi(TS_SEC / LS_HENRY * SCALE);
  localparam logic signed [WIDTH-1:0] TS_FX     = $rtoi(TS_SEC * SCALE);

  logic                    pending;
  logic signed [WIDTH-1:0] v_alpha, v_beta, cos_th, sin_th;
  logic signed [WIDTH-1:0] emf, emf_sin, emf_cos, drop_a, drop_b, drive_a, drive_b, dtheta;

  // Back-EMF and resistive drop from the previous corrected state
  assign emf     = WIDTH'(q_mul(LAM_TS_LS, x_2_i, FRAC));
  assign emf_sin = WIDTH'(q_mul(emf, sin_th, FRAC));
  assign emf_cos = WIDTH'(q_mul(emf, cos_th, FRAC));
  assign drop_a  = WIDTH'(q_mul(RS_TS_LS, x_0_i, FRAC));
  assign drop_b  = WIDTH'(q_mul(RS_TS_LS, x_1_i, FRAC));
  assign drive_a = WIDTH'(q_mul(v_alpha, TS_LS, FRAC));
  assign drive_b = WIDTH'(q_mul(v_beta, TS_LS, FRAC));
  assign dtheta  = WIDTH'(q_mul(x_2_i, TS_FX, FRAC));

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      pending        <= 1'b0;
      predict_done_o <= 1'b0;
    end else begin
      pending        <= sample_valid_i && sample_ready_i;
      predict_done_o <= pending;
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid_i && sample_ready_i) begin
      v_alpha      <= v_alpha_i;
      v_beta       <= v_beta_i;
      cos_th       <= cos_theta_i;
      sin_th       <= sin_theta_i;
      meas_alpha_o <= i_alpha_meas_i;
      meas_beta_o  <= i_beta_meas_i;
    end
    if (pending) begin
      xe_0_o   <= x_0_i + (drive_a - drop_a + emf_sin);
      xe_1_o   <= x_1_i + (drive_b - drop_b - emf_cos);
      xe_2_o   <= x_2_i;
      xe_3_o   <= x_3_i + dtheta;
      jac_02_o <= WIDTH'(q_mul(LAM_TS_LS, sin_th, FRAC));
      jac_03_o <= emf_cos;
      jac_12_o <= -WIDTH'(q_mul(LAM_TS_LS, cos_th, FRAC));
      jac_13_o <= emf_sin;
    end
  end

endmodule

//--- hw/state_correct.sv
// State correction: applies the gain to the current innovation and holds the filter outputs
`timescale 1ns/1ps

module state_correct
  import kalman_pkg::*;
#(
  parameter int WIDTH = 32,
  parameter int FRAC  = 18
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sample_valid_i,
  input  logic                    gain_valid_i,
  input  logic signed [WIDTH-1:0] xe_0_i,
  input  logic signed [WIDTH-1:0] xe_1_i,
  input  logic signed [WIDTH-1:0] xe_2_i,
  input  logic signed [WIDTH-1:0] xe_3_i,
  input  logic signed [WIDTH-1:0] meas_alpha_i,
  input  logic signed [WIDTH-1:0] meas_beta_i,
  input  logic signed [WIDTH-1:0] k_00_i,
  input  logic signed [WIDTH-1:0] k_01_i,
  input  logic signed [WIDTH-1:0] k_10_i,
  input  logic signed [WIDTH-1:0] k_11_i,
  input  logic signed [WIDTH-1:0] k_20_i,
  input  logic signed [WIDTH-1:0] k_21_i,
  input  logic signed [WIDTH-1:0] k_30_i,
  input  logic signed [WIDTH-1:0] k_31_i,
  output logic signed [WIDTH-1:0] x_0_o,
  output logic signed [WIDTH-1:0] x_1_o,
  output logic signed [WIDTH-1:0] x_2_o,
  output logic signed [WIDTH-1:0] x_3_o,
  output logic                    step_done_o,
  output logic                    idle_o,
  output logic                    result_valid_o,
  output logic signed [WIDTH-1:0] i_alpha_est_o,
  output logic signed [WIDTH-1:0] i_beta_est_o,
  output logic signed [WIDTH-1:0] omega_est_o,
  output logic signed [WIDTH-1:0] theta_est_o
);

  logic signed [WIDTH-1:0] inn_a, inn_b;

  // Innovation on the two measured currents
  assign inn_a = meas_alpha_i - xe_0_i;
  assign inn_b = meas_beta_i - xe_1_i;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      x_0_o          <= '0;
      x_1_o          <= '0;
      x_2_o          <= '0;
      x_3_o          <= '0;
      idle_o         <= 1'b1;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= gain_valid_i;
      if (sample_valid_i && idle_o) begin
        idle_o <= 1'b0;
      end else if (gain_valid_i) begin
        idle_o <= 1'b1;
      end
      if (gain_valid_i) begin
        x_0_o <= xe_0_i + WIDTH'(q_mul(k_00_i, inn_a, FRAC)) + WIDTH'(q_mul(k_01_i, inn_b, FRAC));
        x_1_o <= xe_1_i + WIDTH'(q_mul(k_10_i, inn_a, FRAC)) + WIDTH'(q_mul(k_11_i, inn_b, FRAC));
        x_2_o <= xe_2_i + WIDTH'(q_mul(k_20_i, inn_a, FRAC)) + WIDTH'(q_mul(k_21_i, inn_b, FRAC));
        x_3_o <= xe_3_i + WIDTH'(q_mul(k_30_i, inn_a, FRAC)) + WIDTH'(q_mul(k_31_i, inn_b, FRAC));
      end
    end
  end

  // Estimates are the corrected state; step completion coincides with the result
  assign step_done_o   = result_valid_o;
  assign i_alpha_est_o = x_0_o;
  assign i_beta_est_o  = x_1_o;
  assign omega_est_o   = x_2_o;
  assign theta_est_o   = x_3_o;

endmodule

//--- hw/kalman_top.sv
// EKF top level joining mean prediction, covariance sequencer and state correction
`timescale 1ns/1ps

module kalman_top #(
  parameter int WIDTH = 32,
  parameter int FRAC  = 18
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sample_valid_i,
  output logic                    sample_ready_o,
  input  logic signed [WIDTH-1:0] v_alpha_i,
  input  logic signed [WIDTH-1:0] v_beta_i,
  input  logic signed [WIDTH-1:0] i_alpha_meas_i,
  input  logic signed [WIDTH-1:0] i_beta_meas_i,
  input  logic signed [WIDTH-1:0] cos_theta_i,
  input  logic signed [WIDTH-1:0] sin_theta_i,
  output logic                    result_valid_o,
  output logic signed [WIDTH-1:0] i_alpha_est_o,
  output logic signed [WIDTH-1:0] i_beta_est_o,
  output logic signed [WIDTH-1:0] omega_est_o,
  output logic signed [WIDTH-1:0] theta_est_o
);

  logic                    idle, predict_done, gain_valid, step_done;
  logic signed [WIDTH-1:0] x_0, x_1, x_2, x_3;
  logic signed [WIDTH-1:0] xe_0, xe_1, xe_2, xe_3;
  logic signed [WIDTH-1:0] jac_02, jac_03, jac_12, jac_13;
  logic signed [WIDTH-1:0] meas_alpha, meas_beta;
  logic signed [WIDTH-1:0] k_00, k_01, k_10, k_11, k_20, k_21, k_30, k_31;

  // New samples are taken only between filter steps
  assign sample_ready_o = idle;

  state_predict #(.WIDTH(WIDTH), .FRAC(FRAC)) u_predict (
    .clk, .reset, .sample_valid_i, .sample_ready_i(idle),
    .v_alpha_i, .v_beta_i, .i_alpha_meas_i, .i_beta_meas_i, .cos_theta_i, .sin_theta_i,
    .x_0_i(x_0), .x_1_i(x_1), .x_2_i(x_2), .x_3_i(x_3),
    .predict_done_o(predict_done),
    .xe_0_o(xe_0), .xe_1_o(xe_1), .xe_2_o(xe_2), .xe_3_o(xe_3),
    .jac_02_o(jac_02), .jac_03_o(jac_03), .jac_12_o(jac_12), .jac_13_o(jac_13),
    .meas_alpha_o(meas_alpha), .meas_beta_o(meas_beta)
  );

  covariance_update #(.WIDTH(WIDTH), .FRAC(FRAC)) u_cov (
    .clk, .reset, .predict_done_i(predict_done),
    .jac_02_i(jac_02), .jac_03_i(jac_03), .jac_12_i(jac_12), .jac_13_i(jac_13),
    .step_done_i(step_done), .gain_valid_o(gain_valid),
    .k_00_o(k_00), .k_01_o(k_01), .k_10_o(k_10), .k_11_o(k_11),
    .k_20_o(k_20), .k_21_o(k_21), .k_30_o(k_30), .k_31_o(k_31)
  );

  state_correct #(.WIDTH(WIDTH), .FRAC(FRAC)) u_correct (
    .clk, .reset, .sample_valid_i, .gain_valid_i(gain_valid),
    .xe_0_i(xe_0), .xe_1_i(xe_1), .xe_2_i(xe_2), .xe_3_i(xe_3),
    .meas_alpha_i(meas_alpha), .meas_beta_i(meas_beta),
    .k_00_i(k_00), .k_01_i(k_01), .k_10_i(k_10), .k_11_i(k_11),
    .k_20_i(k_20), .k_21_i(k_21), .k_30_i(k_30), .k_31_i(k_31),
    .x_0_o(x_0), .x_1_o(x_1), .x_2_o(x_2), .x_3_o(x_3),
    .step_done_o(step_done), .idle_o(idle), .result_valid_o,
    .i_alpha_est_o, .i_beta_est_o, .omega_est_o, .theta_est_o
  );

endmodule

//--- verif/ekf_model.svh
// Fixed-point EKF step model, included inside the testbench module after WIDTH and FRAC
`ifndef EKF_MODEL_SVH
`define EKF_MODEL_SVH

typedef logic signed [WIDTH-1:0] mat_t [MAT_DIM*MAT_DIM];

localparam real SCALE = 2.0 ** FRAC;
localparam logic signed [WIDTH-1:0] ONE_FX = WIDTH'(1) << FRAC;
localparam logic signed [WIDTH-1:0] RS_K   = $rtoi(RS_OHM * TS_SEC / LS_HENRY * SCALE);
localparam logic signed [WIDTH-1:0] LAM_K  = $rtoi(LAMBDA_WB * TS_SEC / LS_HENRY * SCALE);
localparam logic signed [WIDTH-1:0] TSL_K  = $rtoi(TS_SEC / LS_HENRY * SCALE);
localparam logic signed [WIDTH-1:0] TS_K   = $rtoi(TS_SEC * SCALE);
localparam logic signed [WIDTH-1:0] R_K    = $rtoi(R_DIAG * SCALE);
localparam logic [WIDTH-1:0]        MAX_FX = {1'b0, {(WIDTH-1){1'b1}}};

// Filter state and covariance as the model sees them
logic signed [WIDTH-1:0] mx [MAT_DIM];
mat_t mp;

// Full signed product, floor shift, low word kept
function automatic logic signed [WIDTH-1:0] fx_mul(input logic signed [63:0] a,
                                                   input logic signed [63:0] b);
  logic signed [127:0] full;
  full = a * b;
  full = full >>> FRAC;
  return full[WIDTH-1:0];
endfunction

function automatic void mat_mul(input mat_t a, input mat_t b, output mat_t c);
  logic signed [WIDTH-1:0] acc;
  for (int r = 0; r < MAT_DIM; r++) begin
    for (int col = 0; col < MAT_DIM; col++) begin
      acc = '0;
      for (int k = 0; k < MAT_DIM; k++) begin
        acc = acc + fx_mul(a[r*MAT_DIM+k], b[k*MAT_DIM+col]);
      end
      c[r*MAT_DIM+col] = acc;
    end
  end
endfunction

// 2^(2*FRAC) over the determinant magnitude, saturated, sign put back
function automatic logic signed [WIDTH-1:0] recip_of(input logic signed [WIDTH-1:0] det);
  logic [WIDTH-1:0] mag;
  logic [63:0]      q;
  mag = det[WIDTH-1] ? -det : det;
  if (mag == '0) begin
    q = 64'(MAX_FX);
  end else begin
    q = (64'd1 << (2 * FRAC)) / 64'(mag);
  end
  if (q > 64'(MAX_FX)) q = 64'(MAX_FX);
  return det[WIDTH-1] ? -WIDTH'(q) : WIDTH'(q);
endfunction

function automatic void clear_model();
  for (int i = 0; i < MAT_DIM; i++) mx[i] = '0;
  for (int i = 0; i < MAT_DIM * MAT_DIM; i++) mp[i] = '0;
  mp[0]  = $rtoi(P_INIT_0 * SCALE);
  mp[5]  = $rtoi(P_INIT_1 * SCALE);
  mp[10] = $rtoi(P_INIT_2 * SCALE);
  mp[15] = $rtoi(P_INIT_3 * SCALE);
endfunction

function automatic void ekf_step(input logic signed [WIDTH-1:0] va, vb, ia, ib, cs, sn);
  logic signed [WIDTH-1:0] emf, s00, s11, det, rc, inn_a, inn_b;
  logic signed [WIDTH-1:0] xe [MAT_DIM];
  mat_t f, ft, fp, pp, pct, inv, k, ikc;
  // Mean prediction
  emf   = fx_mul(LAM_K, mx[2]);
  xe[0] = mx[0] + (fx_mul(va, TSL_K) - fx_mul(RS_K, mx[0]) + fx_mul(emf, sn));
  xe[1] = mx[1] + (fx_mul(vb, TSL_K) - fx_mul(RS_K, mx[1]) - fx_mul(emf, cs));
  xe[2] = mx[2];
  xe[3] = mx[3] + fx_mul(mx[2], TS_K);
  for (int i = 0; i < MAT_DIM * MAT_DIM; i++) begin
    f[i]   = '0;
    inv[i] = '0;
  end
  f[0]  = ONE_FX - RS_K;
  f[2]  = fx_mul(LAM_K, sn);
  f[3]  = fx_mul(emf, cs);
  f[5]  = ONE_FX - RS_K;
  f[6]  = -fx_mul(LAM_K, cs);
  f[7]  = fx_mul(emf, sn);
  f[10] = ONE_FX;
  f[14] = TS_K;
  f[15] = ONE_FX;
  for (int r = 0; r < MAT_DIM; r++) begin
    for (int c = 0; c < MAT_DIM; c++) ft[c*MAT_DIM+r] = f[r*MAT_DIM+c];
  end
  // Predicted covariance plus process noise
  mat_mul(f, mp, fp);
  mat_mul(fp, ft, pp);
  pp[0]  = pp[0] + WIDTH'($rtoi(Q_DIAG_0 * SCALE));
  pp[5]  = pp[5] + WIDTH'($rtoi(Q_DIAG_1 * SCALE));
  pp[10] = pp[10] + WIDTH'($rtoi(Q_DIAG_2 * SCALE));
  pp[15] = pp[15] + WIDTH'($rtoi(Q_DIAG_3 * SCALE));
  // Innovation inverse through the adjugate
  s00    = pp[0] + R_K;
  s11    = pp[5] + R_K;
  det    = fx_mul(s00, s11) - fx_mul(pp[4], pp[1]);
  rc     = recip_of(det);
  inv[0] = fx_mul(s11, rc);
  inv[1] = fx_mul(-pp[1], rc);
  inv[4] = fx_mul(-pp[4], rc);
  inv[5] = fx_mul(s00, rc);
  for (int i = 0; i < MAT_DIM * MAT_DIM; i++) begin
    pct[i] = (i % MAT_DIM < MEAS_DIM) ? pp[i] : '0;
  end
  mat_mul(pct, inv, k);
  for (int r = 0; r < MAT_DIM; r++) begin
    for (int c = 0; c < MAT_DIM; c++) begin
      ikc[r*MAT_DIM+c] = ((r == c) ? ONE_FX : '0) - ((c < MEAS_DIM) ? k[r*MAT_DIM+c] : '0);
    end
  end
  // Correction of the mean and new covariance
  inn_a = ia - xe[0];
  inn_b = ib - xe[1];
  for (int r = 0; r < MAT_DIM; r++) begin
    mx[r] = xe[r] + fx_mul(k[r*MAT_DIM], inn_a) + fx_mul(k[r*MAT_DIM+1], inn_b);
  end
  mat_mul(ikc, pp, mp);
endfunction

`endif

//--- verif/kalman_tb.sv
// Testbench for the EKF top level: random samples checked against the included step model
`timescale 1ns/1ps

module kalman_tb
  import kalman_pkg::*;
();

  localparam int WIDTH          = 32;
  localparam int FRAC           = 18;
  localparam int RANDOM_SAMPLES = 200;
  localparam int ZERO_SAMPLES   = 24;
  localparam int TOTAL          = RANDOM_SAMPLES + ZERO_SAMPLES;
  // Four multiplies, one division and handshake overhead per step, plus the largest gap
  localparam int STEP_CYCLES    = 4 * 20 + WIDTH + FRAC + 10;
  localparam int MAX_CYCLES     = TOTAL * (STEP_CYCLES + 8) + 100;
  localparam int AMP_VI         = 4 << FRAC;
  localparam int AMP_TRIG       = 1 << FRAC;

  logic                    clk;
  logic                    reset;
  logic                    sample_valid, sample_ready, result_valid;
  logic signed [WIDTH-1:0] v_alpha, v_beta, i_alpha_meas, i_beta_meas, cos_theta, sin_theta;
  logic signed [WIDTH-1:0] i_alpha_est, i_beta_est, omega_est, theta_est;

  logic [31:0]             rng_state;
  int                      cycles;
  int                      results;
  logic                    prev_valid;
  logic [4*WIDTH-1:0]      expect_q [$];
  logic signed [WIDTH-1:0] held [4];

  `include "ekf_model.svh"

  kalman_top #(.WIDTH(WIDTH), .FRAC(FRAC)) dut0 (
    .clk(clk), .reset(reset),
    .sample_valid_i(sample_valid), .sample_ready_o(sample_ready),
    .v_alpha_i(v_alpha), .v_beta_i(v_beta),
    .i_alpha_meas_i(i_alpha_meas), .i_beta_meas_i(i_beta_meas),
    .cos_theta_i(cos_theta), .sin_theta_i(sin_theta),
    .result_valid_o(result_valid),
    .i_alpha_est_o(i_alpha_est), .i_beta_est_o(i_beta_est),
    .omega_est_o(omega_est), .theta_est_o(theta_est)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand();
    logic [31:0] s;
    s = rng_state;
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    rng_state = s;
    return s;
  endfunction

  // Uniform value in [-amp, amp]
  function automatic logic signed [WIDTH-1:0] rand_fixed(input int amp);
    logic [31:0] r;
    r = next_rand();
    return WIDTH'(int'(r % 32'(2 * amp + 1)) - amp);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic signed [WIDTH-1:0] got,
                             input logic signed [WIDTH-1:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("FAIL time %0t %s: got %0d, expected %0d",
                          $time, name, got, expected));
    end
  endtask

  // Estimates must match the latest expected step, on the pulse and while holding
  task automatic watch_outputs();
    logic [4*WIDTH-1:0] exp_w;
    if (result_valid) begin
      if (prev_valid) abort_run("result_valid_o stayed high for more than one cycle");
      if (expect_q.size() == 0) abort_run("result_valid_o pulsed with no sample accepted");
      exp_w = expect_q.pop_front();
      for (int i = 0; i < 4; i++) held[i] = exp_w[i*WIDTH +: WIDTH];
      results++;
    end
    check_value("i_alpha_est_o", i_alpha_est, held[0]);
    check_value("i_beta_est_o", i_beta_est, held[1]);
    check_value("omega_est_o", omega_est, held[2]);
    check_value("theta_est_o", theta_est, held[3]);
    prev_valid = result_valid;
  endtask

  task automatic tick();
    @(negedge clk);
    cycles++;
    if (cycles > MAX_CYCLES) abort_run("Timeout: the filter stopped producing results");
    watch_outputs();
  endtask

  task automatic drive_sample(input logic valid,
                              input logic signed [WIDTH-1:0] va, vb, ia, ib, cs, sn);
    sample_valid = valid;
    v_alpha      = va;
    v_beta       = vb;
    i_alpha_meas = ia;
    i_beta_meas  = ib;
    cos_theta    = cs;
    sin_theta    = sn;
  endtask

  initial begin
    logic [31:0]             junk;
    int                      gap;
    logic signed [WIDTH-1:0] va, vb, ia, ib, cs, sn;
    rng_state  = 32'h9679_f3bf;
    cycles     = 0;
    results    = 0;
    prev_valid = 1'b0;
    reset      = 1'b0;
    drive_sample(1'b0, '0, '0, '0, '0, '0, '0);
    for (int i = 0; i < 4; i++) held[i] = '0;
    clear_model();

    repeat (5) @(negedge clk);
    reset = 1'b1;
    if (!sample_ready) abort_run("sample_ready_o is low after reset");
    if (result_valid) abort_run("result_valid_o is high after reset");
    watch_outputs();

    for (int n = 0; n < TOTAL; n++) begin
      // Samples offered while busy must be ignored
      while (!sample_ready) begin
        junk = next_rand();
        drive_sample(junk[0], rand_fixed(AMP_VI), rand_fixed(AMP_VI), rand_fixed(AMP_VI),
                     rand_fixed(AMP_VI), rand_fixed(AMP_TRIG), rand_fixed(AMP_TRIG));
        tick();
      end
      sample_valid = 1'b0;
      gap = int'(next_rand() % 8);
      repeat (gap) tick();
      cs = rand_fixed(AMP_TRIG);
      sn = rand_fixed(AMP_TRIG);
      if (n < RANDOM_SAMPLES) begin
        va = rand_fixed(AMP_VI);
        vb = rand_fixed(AMP_VI);
        ia = rand_fixed(AMP_VI);
        ib = rand_fixed(AMP_VI);
      end else begin
        // Unforced run, speed and angle decay through the gain
        va = '0;
        vb = '0;
        ia = '0;
        ib = '0;
      end
      drive_sample(1'b1, va, vb, ia, ib, cs, sn);
      ekf_step(va, vb, ia, ib, cs, sn);
      expect_q.push_back({mx[3], mx[2], mx[1], mx[0]});
      tick();
      sample_valid = 1'b0;
    end

    while (results < TOTAL) tick();
    repeat (4) tick();

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- src.f
+incdir+verif
common/kalman_pkg.sv
hw/covariance/mat_mult_seq.sv
hw/covariance/recip_div.sv
hw/covariance/covariance_update.sv
hw/predict/state_predict.sv
hw/state_correct.sv
hw/kalman_top.sv
verif/kalman_tb.sv

//--- run.sh
#!/bin/sh
# Builds the EKF testbench with Verilator, runs it and checks the log for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module kalman_tb \
  -f src.f \
  -o Vkalman_tb

./obj_dir/Vkalman_tb | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
